// ==== djSequencer.f ====
+incdir+verification
rtl/seqPkg.sv
rtl/tonePkg.sv
rtl/sequencerControl.sv
rtl/trackMemory.sv
rtl/stepTimer.sv
rtl/squareToneGen.sv
rtl/sampleMixer.sv
rtl/djSequencerTop.sv
verification/djSequencerTb.sv

// ==== runSim.sh ====
#!/bin/bash
# Build and run the sequencer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f djSequencer.f --top-module djSequencerTb -o simv
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

output=$(./obj_dir/simv)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "all tests passed"; then
	exit 0
else
	exit 1
fi

// ==== verification/tbStimulus.svh ====
//****************************************
// Stimulus table for the sequencer testbench
// Track 0 holds only C, so its tone never restarts
// Half-period assumes periodShift of 10
//****************************************
`ifndef TB_STIMULUS_SVH
`define TB_STIMULUS_SVH

localparam int numNotes = 15;

// Recorded in order, track 0 slots 0 to 4 first
localparam tonePkg::noteT recordNotes [0:numNotes-1] = '{
	8'h01, 8'h01, 8'h01, 8'h01, 8'h01, // Track 0, all C
	8'h02, 8'h04, 8'h00, 8'h08, 8'h10, // Track 1, rest in slot 2
	8'h20, 8'h40, 8'h80, 8'h03, 8'h01  // Track 2, bad code in slot 3
};

// Whether each recorded note sounds at all
localparam bit noteSounds [0:numNotes-1] = '{
	1'b1, 1'b1, 1'b1, 1'b1, 1'b1,
	1'b1, 1'b1, 1'b0, 1'b1, 1'b1,
	1'b1, 1'b1, 1'b1, 1'b0, 1'b1
};

localparam int numPatterns = 4;

localparam seqPkg::trackSelT enablePatterns [0:numPatterns-1] = '{
	3'b111, 3'b101, 3'b011, 3'b110
};

localparam int halfPeriodC = 95; // 97304 >> 10
localparam int periodSlack = 2;

`endif

// ==== verification/djSequencerTb.sv ====
//****************************************
// Testbench for the step sequencer top
// Runs with stepCycles 40 and periodShift 10
//****************************************
`timescale 1ns/1ps

module djSequencerTb;

	`include "tbStimulus.svh"

	localparam int stepCyclesTb  = 40;
	localparam int pressCycles   = 6;
	localparam int stepChecks    = 5;
	localparam int patternCycles = 3 + stepChecks * stepCyclesTb;
	localparam int toneCycles    = 8 * halfPeriodC;
	localparam int tableCycles   = pressCycles * (numNotes + 2) +
		numPatterns * patternCycles + toneCycles + 200;
	localparam int cycleLimit    = 2 * tableCycles + 2000;

	logic             clk;
	logic             reset;
	logic             go;
	tonePkg::noteT    noteIn;
	seqPkg::trackSelT trackEnable;
	logic             inAvailable;
	logic             outAllowed;
	tonePkg::sampleT  leftIn;
	tonePkg::sampleT  rightIn;
	logic             sampleRead;
	logic             sampleWrite;
	tonePkg::sampleT  leftOut;
	tonePkg::sampleT  rightOut;
	seqPkg::seqPhaseT phase;
	seqPkg::slotT     playSlot0;
	seqPkg::slotT     playSlot1;
	seqPkg::slotT     playSlot2;

	int              errors;
	int              mixErrors;
	int              checks;
	int              cycleCount;
	bit              randInputs;
	bit              checkMix;
	tonePkg::sampleT loadedLeft;  // Input sample taken at the last edge
	tonePkg::sampleT loadedRight;
	logic            loadedStrobe;
	logic [11:0]     lastKey;
	int              stableCnt;

	djSequencerTop #(
		.stepCycles  (stepCyclesTb),
		.periodShift (10)
	) dut_i (
		.clk         (clk),
		.reset       (reset),
		.go          (go),
		.noteIn      (noteIn),
		.trackEnable (trackEnable),
		.inAvailable (inAvailable),
		.outAllowed  (outAllowed),
		.leftIn      (leftIn),
		.rightIn     (rightIn),
		.sampleRead  (sampleRead),
		.sampleWrite (sampleWrite),
		.leftOut     (leftOut),
		.rightOut    (rightOut),
		.phase       (phase),
		.playSlot0   (playSlot0),
		.playSlot1   (playSlot1),
		.playSlot2   (playSlot2)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	//****************************************
	// Helpers
	//****************************************
	// Advance n rising edges with new random samples on each
	task automatic tick(input int n);
		for (int i = 0; i < n; i++) begin
			@(posedge clk);
			if (randInputs) begin
				leftIn  <= $urandom;
				rightIn <= $urandom;
			end
		end
	endtask

	task automatic pressGo();
		go <= 1'b1;
		tick(3);
		go <= 1'b0;
		tick(3);
	endtask

	function automatic int slotOf(input int t);
		case (t)
			0:       return int'(playSlot0);
			1:       return int'(playSlot1);
			default: return int'(playSlot2);
		endcase
	endfunction

	task automatic checkPhase(input seqPkg::seqPhaseT expected);
		checks++;
		if (phase != expected) begin
			$display("Error phase: got %h, expected %h", phase, expected);
			errors++;
		end
	endtask

	//****************************************
	// Mix checker on every falling edge
	//****************************************
	always @(posedge clk) begin
		loadedLeft   <= leftIn;
		loadedRight  <= rightIn;
		loadedStrobe <= sampleWrite;
	end

	always @(negedge clk) begin
		int diffL;
		int diffR;
		int k;
		int kAbs;
		int nTones;
		if ({trackEnable, playSlot0, playSlot1, playSlot2} == lastKey) begin
			stableCnt = stableCnt + 1;
		end else begin
			stableCnt = 0;
		end
		lastKey = {trackEnable, playSlot0, playSlot1, playSlot2};
		if (checkMix && loadedStrobe && stableCnt >= 3) begin
			diffL  = leftOut - loadedLeft;
			diffR  = rightOut - loadedRight;
			nTones = 0;
			for (int t = 0; t < 3; t++) begin
				if (trackEnable[t] && noteSounds[t * 5 + slotOf(t)]) begin
					nTones++;
				end
			end
			k    = diffL / 10000000;
			kAbs = (k < 0) ? -k : k;
			checks++;
			if (diffL % 10000000 != 0 || kAbs > nTones || ((k + nTones) % 2) != 0) begin
				$display("Error leftOut: got %h, input %h, %0d tones expected",
					leftOut, loadedLeft, nTones);
				mixErrors++;
			end
			if (diffR != diffL) begin
				$display("Error rightOut: got %h, expected %h", rightOut, loadedRight + diffL);
				mixErrors++;
			end
		end
	end

	// Timeout
	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("Timeout after %0d cycles, the run did not finish", cycleCount);
			$display("tests failed");
			$finish;
		end
	end

	//****************************************
	// Main sequence
	//****************************************
	initial begin
		int oldSlot [0:2];
		int lastChange;
		int interval;
		int seedDummy;
		bit lastNeg;
		tonePkg::sampleT holdLeft;
		tonePkg::sampleT holdRight;
		errors      = 0;
		mixErrors   = 0;
		checks      = 0;
		cycleCount  = 0;
		randInputs  = 1'b0;
		checkMix    = 1'b0;
		stableCnt   = 0;
		lastKey     = '0;
		seedDummy   = $urandom(32'h3389_9f31);
		reset       = 1'b0;
		go          = 1'b0;
		noteIn      = '0;
		trackEnable = 3'b111;
		inAvailable = 1'b1;
		outAllowed  = 1'b1;
		leftIn      = '0;
		rightIn     = '0;

		tick(4);
		@(negedge clk);
		checkPhase(seqPkg::phaseIdle);
		checks++;
		if (leftOut != 0 || rightOut != 0) begin
			$display("Error leftOut/rightOut after reset: %h %h", leftOut, rightOut);
			errors++;
		end
		if (playSlot0 != 0 || playSlot1 != 0 || playSlot2 != 0) begin
			$display("Error playSlot after reset: %h %h %h", playSlot0, playSlot1, playSlot2);
			errors++;
		end
		tick(1);
		reset      <= 1'b1;
		randInputs = 1'b1;
		tick(2);

		// Record fifteen notes
		pressGo();
		@(negedge clk);
		checkPhase(seqPkg::phaseRecord);
		tick(1);
		for (int i = 0; i < numNotes; i++) begin
			noteIn <= recordNotes[i];
			pressGo();
		end
		@(negedge clk);
		checkPhase(seqPkg::phasePlay);
		checkMix = 1'b1;
		tick(1);

		// One step check per stepCycles for each enable pattern
		for (int p = 0; p < numPatterns; p++) begin
			trackEnable <= enablePatterns[p];
			tick(3);
			@(negedge clk);
			for (int t = 0; t < 3; t++) oldSlot[t] = slotOf(t);
			for (int s = 0; s < stepChecks; s++) begin
				tick(stepCyclesTb);
				@(negedge clk);
				for (int t = 0; t < 3; t++) begin
					checks++;
					if (enablePatterns[p][t] && slotOf(t) != (oldSlot[t] + 1) % 5) begin
						$display("Error playSlot%0d: got %h, expected %h",
							t, slotOf(t), (oldSlot[t] + 1) % 5);
						errors++;
					end
					if (!enablePatterns[p][t] && slotOf(t) != oldSlot[t]) begin
						$display("Error playSlot%0d: got %h, expected %h",
							t, slotOf(t), oldSlot[t]);
						errors++;
					end
					oldSlot[t] = slotOf(t);
				end
			end
		end

		// Tone period on track 0 alone with inputs at zero
		randInputs = 1'b0;
		trackEnable <= 3'b001;
		leftIn      <= '0;
		rightIn     <= '0;
		tick(10);
		@(negedge clk);
		lastNeg    = leftOut < 0;
		lastChange = -1;
		for (int n = 0; n < 6; ) begin
			tick(1);
			@(negedge clk);
			if ((leftOut < 0) != lastNeg) begin
				lastNeg = leftOut < 0;
				if (lastChange >= 0) begin
					interval = cycleCount - lastChange;
					checks++;
					if (interval < halfPeriodC - periodSlack ||
						interval > halfPeriodC + periodSlack) begin
						$display("Error leftOut half-period: got %h cycles, expected %h",
							interval, halfPeriodC);
						errors++;
					end
					n++;
				end
				lastChange = cycleCount;
			end
		end

		// Back-pressure holds the outputs
		randInputs = 1'b1;
		tick(1);
		outAllowed <= 1'b0;
		@(negedge clk);
		holdLeft  = leftOut;
		holdRight = rightOut;
		for (int i = 0; i < 20; i++) begin
			tick(1);
			@(negedge clk);
			checks++;
			if (sampleWrite !== 1'b0) begin
				$display("Error sampleWrite: got %h, expected 0", sampleWrite);
				errors++;
			end
			if (sampleRead !== 1'b0) begin
				$display("Error sampleRead: got %h, expected 0", sampleRead);
				errors++;
			end
			if (leftOut != holdLeft || rightOut != holdRight) begin
				$display("Error leftOut/rightOut: got %h %h, expected %h %h",
					leftOut, rightOut, holdLeft, holdRight);
				errors++;
			end
		end
		tick(1);
		outAllowed <= 1'b1;
		checkMix = 1'b0;

		// Leave play
		pressGo();
		@(negedge clk);
		checkPhase(seqPkg::phaseIdle);
		checks++;
		if (playSlot0 != 0 || playSlot1 != 0 || playSlot2 != 0) begin
			$display("Error playSlot after play: %h %h %h", playSlot0, playSlot1, playSlot2);
			errors++;
		end
		checks++;
		if (sampleRead !== 1'b1 || sampleWrite !== 1'b1) begin
			$display("Error sampleRead/sampleWrite: got %h %h, expected 1 1",
				sampleRead, sampleWrite);
			errors++;
		end

		$display("Checks: %0d, errors: %0d, mix errors: %0d", checks, errors, mixErrors);
		if (errors == 0 && mixErrors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// ==== rtl/djSequencerTop.sv ====
//****************************************
// Three-track step sequencer top
// stepCycles is clocks per step, 50000000 is one second at 50 MHz
// periodShift shortens every tone, keep 0 for real pitch
//****************************************
`timescale 1ns/1ps

module djSequencerTop #(
	parameter int stepCycles  = 50000000,
	parameter int periodShift = 0
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              go,
	input  tonePkg::noteT     noteIn,
	input  seqPkg::trackSelT  trackEnable,
	input  logic              inAvailable,
	input  logic              outAllowed,
	input  tonePkg::sampleT   leftIn,
	input  tonePkg::sampleT   rightIn,
	output logic              sampleRead,
	output logic              sampleWrite,
	output tonePkg::sampleT   leftOut,
	output tonePkg::sampleT   rightOut,
	output seqPkg::seqPhaseT  phase,
	output seqPkg::slotT      playSlot0,
	output seqPkg::slotT      playSlot1,
	output seqPkg::slotT      playSlot2
);

	logic             goEdge;
	logic             playing;
	logic             stepTick;
	seqPkg::trackSelT writeTrack;
	seqPkg::slotT     writeSlot;

	// Per-track signals
	tonePkg::noteT    trackNote [0:seqPkg::numTracks-1];
	tonePkg::sampleT  trackTone [0:seqPkg::numTracks-1];
	seqPkg::slotT     trackSlot [0:seqPkg::numTracks-1];

	//****************************************
	// Control and timing
	//****************************************
	sequencerControl control_i (
		.clk        (clk),
		.reset      (reset),
		.go         (go),
		.goEdge     (goEdge),
		.writeTrack (writeTrack),
		.writeSlot  (writeSlot),
		.playing    (playing),
		.phase      (phase)
	);

	stepTimer #(
		.stepCycles (stepCycles)
	) timer_i (
		.clk      (clk),
		.reset    (reset),
		.goEdge   (goEdge),
		.stepTick (stepTick)
	);

	//****************************************
	// Tracks, one store and one tone each
	//****************************************
	for (genvar t = 0; t < seqPkg::numTracks; t++) begin : gTrack
		trackMemory memory_i (
			.clk       (clk),
			.reset     (reset),
			.writeEn   (writeTrack[t]),
			.writeSlot (writeSlot),
			.noteIn    (noteIn),
			.playing   (playing),
			.enable    (trackEnable[t]),
			.stepTick  (stepTick),
			.note      (trackNote[t]),
			.playSlot  (trackSlot[t])
		);

		squareToneGen #(
			.periodShift (periodShift)
		) tone_i (
			.clk   (clk),
			.reset (reset),
			.note  (trackNote[t]),
			.tone  (trackTone[t])
		);
	end

	assign playSlot0 = trackSlot[0];
	assign playSlot1 = trackSlot[1];
	assign playSlot2 = trackSlot[2];

	// Mixer on the codec side
	sampleMixer mixer_i (
		.clk         (clk),
		.reset       (reset),
		.inAvailable (inAvailable),
		.outAllowed  (outAllowed),
		.leftIn      (leftIn),
		.rightIn     (rightIn),
		.tone0       (trackTone[0]),
		.tone1       (trackTone[1]),
		.tone2       (trackTone[2]),
		.sampleRead  (sampleRead),
		.sampleWrite (sampleWrite),
		.leftOut     (leftOut),
		.rightOut    (rightOut)
	);

endmodule

// ==== rtl/sampleMixer.sv ====
//****************************************
// Adds the three tones to the passing stereo stream
// Sums wrap, there is no saturation
// Outputs hold while no sample is read
//****************************************
`timescale 1ns/1ps

module sampleMixer (
	input  logic            clk,
	input  logic            reset,
	input  logic            inAvailable,
	input  logic            outAllowed,
	input  tonePkg::sampleT leftIn,
	input  tonePkg::sampleT rightIn,
	input  tonePkg::sampleT tone0,
	input  tonePkg::sampleT tone1,
	input  tonePkg::sampleT tone2,
	output logic            sampleRead,
	output logic            sampleWrite,
	output tonePkg::sampleT leftOut,
	output tonePkg::sampleT rightOut
);

	logic            strobe;
	tonePkg::sampleT toneSum;

	assign strobe      = inAvailable & outAllowed; // Read and write together
	assign sampleRead  = strobe;
	assign sampleWrite = strobe;

	assign toneSum = tone0 + tone1 + tone2;

	always_ff @(posedge clk) begin
		if (!reset) begin
			leftOut  <= '0;
			rightOut <= '0;
		end else if (strobe) begin
			leftOut  <= leftIn + toneSum;
			rightOut <= rightIn + toneSum;
		end
	end

endmodule

// ==== rtl/squareToneGen.sv ====
//****************************************
// Square tone for one track
// Half-period is the table value shifted right by periodShift
// Rests and codes that are not one-hot give zero
//****************************************
`timescale 1ns/1ps

module squareToneGen #(
	parameter int periodShift = 0
) (
	input  logic           clk,
	input  logic           reset,
	input  tonePkg::noteT  note,
	output tonePkg::sampleT tone
);

	tonePkg::halfPeriodT halfPeriod;
	tonePkg::halfPeriodT count;
	tonePkg::noteT       lastNote;
	logic                valid;
	logic                polarity; // High for the positive half
	logic                noteChanged;

	//****************************************
	// Half-period lookup
	//****************************************
	always_comb begin
		halfPeriod = '0;
		valid      = 1'b0;
		for (int i = 0; i < 8; i++) begin
			if (note == tonePkg::noteT'(1 << i)) begin
				halfPeriod = tonePkg::halfPeriodTable[i] >> periodShift;
				valid      = 1'b1;
			end
		end
	end

	assign noteChanged = (note != lastNote);

	// Toggle counter
	always_ff @(posedge clk) begin
		if (!reset) begin
			count    <= '0;
			polarity <= 1'b1;
			lastNote <= '0;
		end else begin
			lastNote <= note;
			if (noteChanged) begin
				count    <= '0;   // Restart on a new note
				polarity <= 1'b1;
			end else if (count == halfPeriod - tonePkg::halfPeriodT'(1)) begin
				count    <= '0;
				polarity <= ~polarity;
			end else begin
				count <= count + tonePkg::halfPeriodT'(1);
			end
		end
	end

	// New note shows positive from its first cycle
	assign tone = !valid ? '0 :
		(polarity || noteChanged) ? tonePkg::toneAmplitude : -tonePkg::toneAmplitude;

endmodule

// ==== rtl/stepTimer.sv ====
//****************************************
// Step timer, one pulse per stepCycles clocks
// A go edge restarts the count with a pulse
//****************************************
`timescale 1ns/1ps

module stepTimer #(
	parameter int stepCycles = 50000000
) (
	input  logic clk,
	input  logic reset,
	input  logic goEdge,
	output logic stepTick
);

	localparam int cntWidth = $clog2(stepCycles + 1);

	logic [cntWidth-1:0] count;

	always_ff @(posedge clk) begin
		if (!reset) begin
			count    <= '0;
			stepTick <= 1'b0;
		end else if (goEdge || count == cntWidth'(stepCycles - 1)) begin
			count    <= '0;
			stepTick <= 1'b1;
		end else begin
			count    <= count + cntWidth'(1);
			stepTick <= 1'b0;
		end
	end

endmodule

// ==== rtl/trackMemory.sv ====
//****************************************
// Five-slot note store for one track
// The pointer only moves in play with the track enabled
// Stored notes are not cleared by reset
//****************************************
`timescale 1ns/1ps

module trackMemory (
	input  logic          clk,
	input  logic          reset,
	input  logic          writeEn,
	input  seqPkg::slotT  writeSlot,
	input  tonePkg::noteT noteIn,
	input  logic          playing,
	input  logic          enable,
	input  logic          stepTick,
	output tonePkg::noteT note,
	output seqPkg::slotT  playSlot
);

	tonePkg::noteT slots [0:seqPkg::slotsPerTrack-1];
	logic          atLastSlot;

	// Note store
	always_ff @(posedge clk) begin
		if (writeEn) begin
			slots[writeSlot] <= noteIn;
		end
	end

	assign atLastSlot = (playSlot == seqPkg::slotT'(seqPkg::slotsPerTrack - 1));

	//****************************************
	// Play pointer and current note
	//****************************************
	always_ff @(posedge clk) begin
		if (!reset) begin
			playSlot <= '0;
			note     <= '0;
		end else begin
			if (!playing) begin
				playSlot <= '0; // Back to the first slot outside play
			end else if (stepTick && enable) begin
				playSlot <= atLastSlot ? '0 : playSlot + seqPkg::slotT'(1);
			end

			// Disabled track is silent
			note <= (playing && enable) ? slots[playSlot] : '0;
		end
	end

endmodule

// ==== rtl/sequencerControl.sv ====
//****************************************
// Phase FSM and record counters
// go is a level and must be clean, no debounce here
// Slots fill track 0 first, five per track
//****************************************
`timescale 1ns/1ps

module sequencerControl (
	input  logic              clk,
	input  logic              reset,
	input  logic              go,
	output logic              goEdge,
	output seqPkg::trackSelT  writeTrack,
	output seqPkg::slotT      writeSlot,
	output logic              playing,
	output seqPkg::seqPhaseT  phase
);

	logic       goReg;
	logic       goPrev;
	logic [1:0] trackIdx; // Track being recorded
	logic       lastSlot;
	logic       lastTrack;

	//****************************************
	// Go edge detection
	//****************************************
	always_ff @(posedge clk) begin
		if (!reset) begin
			goReg  <= 1'b0;
			goPrev <= 1'b0;
		end else begin
			goReg  <= go;
			goPrev <= goReg;
		end
	end

	assign goEdge = goReg & ~goPrev; // High for the cycle after go reads high

	//****************************************
	// Phase FSM and record counters
	//****************************************
	assign lastSlot  = (writeSlot == seqPkg::slotT'(seqPkg::slotsPerTrack - 1));
	assign lastTrack = (trackIdx == 2'(seqPkg::numTracks - 1));

	always_ff @(posedge clk) begin
		if (!reset) begin
			phase     <= seqPkg::phaseIdle;
			writeSlot <= '0;
			trackIdx  <= '0;
		end else if (goEdge) begin
			case (phase)
				seqPkg::phaseIdle: begin
					phase     <= seqPkg::phaseRecord;
					writeSlot <= '0;
					trackIdx  <= '0;
				end
				seqPkg::phaseRecord: begin
					// This edge stores a note, then the counters move on
					if (lastSlot) begin
						writeSlot <= '0;
						if (lastTrack) begin
							trackIdx <= '0;
							phase    <= seqPkg::phasePlay; // Fifteenth note done
						end else begin
							trackIdx <= trackIdx + 2'd1;
						end
					end else begin
						writeSlot <= writeSlot + seqPkg::slotT'(1);
					end
				end
				seqPkg::phasePlay: phase <= seqPkg::phaseIdle;
				default:           phase <= seqPkg::phaseIdle;
			endcase
		end
	end

	// One write enable for the current track, only on a record edge
	assign writeTrack = (phase == seqPkg::phaseRecord && goEdge) ?
		seqPkg::trackSelT'(3'b001 << trackIdx) : '0;

	assign playing = (phase == seqPkg::phasePlay);

endmodule

// ==== rtl/tonePkg.sv ====
//****************************************
// Note, sample and tone constants
// Notes are one-hot, bit 0 is C and bit 7 is high C
// Half-periods assume a 50 MHz clock before any shift
//****************************************

package tonePkg;

	// One-hot note code, zero is a rest
	typedef logic [7:0] noteT;

	// Clock count for half a tone period
	typedef logic [18:0] halfPeriodT;

	// Signed audio sample, same width as the codec words
	typedef logic signed [31:0] sampleT;

	// Indexed by note bit, C up to high C
	localparam halfPeriodT halfPeriodTable [0:7] = '{
		19'd97304,
		19'd88804,
		19'd82304,
		19'd78554,
		19'd71054,
		19'd63554,
		19'd56054,
		19'd52304
	};

	localparam sampleT toneAmplitude = 32'sd10000000; // Peak of each square wave

endpackage

// ==== rtl/seqPkg.sv ====
//****************************************
// Sequencer control types
// Three tracks of five slots each, fixed at build time
// Slot numbers only ever take values 0 to 4
//****************************************

package seqPkg;

	// Phase of the sequencer FSM
	typedef enum logic [1:0] {
		phaseIdle   = 2'd0,
		phaseRecord = 2'd1,
		phasePlay   = 2'd2
	} seqPhaseT;

	// Slot number inside one track
	typedef logic [2:0] slotT;

	// One bit per track, for write and play enables
	typedef logic [2:0] trackSelT;

	localparam int slotsPerTrack = 5;
	localparam int numTracks     = 3;

endpackage
